//--- all.f
verilog/pulse_pkg.sv
verilog/descriptor_fifo.sv
verilog/pulse_generator.sv
verilog/phase_accumulator.sv
verilog/pulse_sequencer_top.sv
bench/pulse_sequencer_sva.sv
bench/pulse_sequencer_tb.sv

//--- bench/pulse_sequencer_sva.sv
module pulse_sequencer_sva
(
  input logic                          aclk,
  input logic                          aresetn,
  input logic                          s_axis_tvalid,
  input logic                          s_axis_tready,
  input logic                          desc_tready,
  input logic [pulse_pkg::PHASE_W-1:0] phase_inc,
  input logic                          sync,
  input logic                          dout,
  input logic [pulse_pkg::PHASE_W-1:0] phase,
  input logic                          gate
);

  int unsigned assert_fails = 0;

  logic [pulse_pkg::FIFO_AW:0] occupancy;  // Words held per the two handshakes
  logic [pulse_pkg::PHASE_W-1:0] phase_model;
  logic sync_last;
  logic dout_model;
  logic model_valid;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      occupancy <= '0;
      model_valid <= 1'b0;
    end
    else
    begin
      model_valid <= 1'b1;
      if (s_axis_tvalid && s_axis_tready && !desc_tready)
      begin
        occupancy <= occupancy + 1'b1;
      end
      else if (desc_tready && !(s_axis_tvalid && s_axis_tready))
      begin
        occupancy <= occupancy - 1'b1;
      end
    end
  end

  // One increment per cycle when no offset was loaded
  always_ff @(posedge aclk)
  begin
    phase_model <= phase + phase_inc;
    sync_last <= sync;
    dout_model <= dout;
  end

  reset_values: assert property (@(posedge aclk)
    $rose(aresetn) |-> s_axis_tready && !sync && !dout && !gate && phase == '0)
  else
  begin
    $error("FAILED %0t tready,sync,dout,gate,phase expected 1,0,0,0,0 actual %b,%b,%b,%b,%h",
      $time, $sampled(s_axis_tready), $sampled(sync), $sampled(dout), $sampled(gate),
      $sampled(phase));
    assert_fails++;
  end

  ready_when_not_full: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axis_tready == (int'(occupancy) != pulse_pkg::FIFO_DEPTH))
  else
  begin
    $error("FAILED %0t s_axis_tready expected %b actual %b", $time,
      int'($sampled(occupancy)) != pulse_pkg::FIFO_DEPTH, $sampled(s_axis_tready));
    assert_fails++;
  end

  phase_follows: assert property (@(posedge aclk)
    model_valid && !sync_last |-> phase == phase_model)
  else
  begin
    $error("FAILED %0t phase expected %h actual %h", $time, $sampled(phase_model),
      $sampled(phase));
    assert_fails++;
  end

  gate_delayed: assert property (@(posedge aclk) model_valid |-> gate == dout_model)
  else
  begin
    $error("FAILED %0t gate expected %b actual %b", $time, $sampled(dout_model), $sampled(gate));
    assert_fails++;
  end

  sync_on_rise: assert property (@(posedge aclk) model_valid |-> sync == (dout && !dout_model))
  else
  begin
    $error("FAILED %0t sync expected %b actual %b", $time,
      $sampled(dout) && !$sampled(dout_model), $sampled(sync));
    assert_fails++;
  end

endmodule

bind pulse_sequencer_top pulse_sequencer_sva sva0
(
  .aclk          (aclk),
  .aresetn       (aresetn),
  .s_axis_tvalid (s_axis_tvalid),
  .s_axis_tready (s_axis_tready),
  .desc_tready   (desc_tready),
  .phase_inc     (phase_inc),
  .sync          (sync),
  .dout          (dout),
  .phase         (phase),
  .gate          (gate)
);

//--- bench/pulse_sequencer_tb.sv
module pulse_sequencer_tb;

  logic aclk;
  logic aresetn;
  logic [pulse_pkg::DESC_W-1:0] s_axis_tdata;
  logic s_axis_tvalid;
  logic s_axis_tready;
  logic [pulse_pkg::PHASE_W-1:0] phase_inc;
  logic sync;
  logic dout;
  logic [pulse_pkg::PHASE_W-1:0] phase;
  logic gate;

  integer seed = 9551;
  pulse_pkg::pulse_desc_u expect_q [$];  // Sent descriptors, oldest first
  pulse_pkg::pulse_desc_u current;
  logic [pulse_pkg::CNT_W-1:0] width_expect;
  logic [pulse_pkg::PHASE_W-1:0] phase_expect;
  logic phase_due = 1'b0;
  int unsigned high_run = 0;
  int unsigned pulses_done = 0;
  int unsigned full_cycles = 0;
  int unsigned bench_errors = 0;
  int unsigned monitor_errors = 0;
  int unsigned errors_before = 0;
  int unsigned pass_count = 0;
  int unsigned fail_count = 0;

  initial aclk = 1'b0;
  always #50 aclk = ~aclk;

  pulse_sequencer_top dut0
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .phase_inc     (phase_inc),
    .sync          (sync),
    .dout          (dout),
    .phase         (phase),
    .gate          (gate)
  );

  function automatic int unsigned error_total();
    return bench_errors + monitor_errors + dut0.sva0.assert_fails;
  endfunction

  // Outputs sampled mid-cycle
  always @(negedge aclk)
  begin
    if (aresetn)
    begin
      if (!s_axis_tready)
      begin
        full_cycles++;
      end
      if (phase_due)
      begin
        assert (phase === phase_expect)
        else
        begin
          $display("FAILED %0t phase expected %h actual %h", $time, phase_expect, phase);
          monitor_errors++;
        end
        phase_due = 1'b0;
      end
      if (sync)
      begin
        assert (expect_q.size() != 0)
        else
        begin
          $display("A sync at %0t came with no descriptor outstanding", $time);
          monitor_errors++;
        end
        if (expect_q.size() != 0)
        begin
          current = expect_q.pop_front();
          width_expect = current.f.fall - current.f.rise;
          phase_expect = current.f.poff;
          phase_due = 1'b1;
        end
      end
      if (dout)
      begin
        high_run++;
      end
      else if (high_run != 0)
      begin
        assert (high_run == width_expect)
        else
        begin
          $display("FAILED %0t dout high cycles expected %0d actual %0d", $time,
            width_expect, high_run);
          monitor_errors++;
        end
        high_run = 0;
        pulses_done++;
      end
    end
  end

  // rise < fall <= stop < 40
  task automatic make_random_desc(output pulse_pkg::pulse_desc_u d);
    int unsigned rise;
    int unsigned width;
    int unsigned tail;
    rise = $unsigned($random(seed)) % 16;
    width = 1 + $unsigned($random(seed)) % 12;
    tail = $unsigned($random(seed)) % (40 - rise - width);
    d.f.rise = rise;
    d.f.fall = rise + width;
    d.f.stop = rise + width + tail;
    d.f.poff = $random(seed);
  endtask

  task automatic send_desc(input pulse_pkg::pulse_desc_u d);
    int unsigned cycles;
    logic accepted;
    logic ready_now;
    cycles = 0;
    accepted = 1'b0;
    s_axis_tdata = d.raw;
    s_axis_tvalid = 1'b1;
    while (!accepted && cycles < 200)
    begin
      ready_now = s_axis_tready;
      if (ready_now)
      begin
        expect_q.push_back(d);
      end
      @(posedge aclk);
      #10;
      accepted = ready_now;
      cycles++;
    end
    if (!accepted)
    begin
      $display("Timed out at %0t waiting for s_axis_tready", $time);
      bench_errors++;
    end
  endtask

  task automatic wait_pulses(input int unsigned target);
    int unsigned cycles;
    cycles = 0;
    while (pulses_done < target && cycles < 3000)
    begin
      @(posedge aclk);
      cycles++;
    end
    #10;
    if (pulses_done < target)
    begin
      $display("Timed out waiting for pulse %0d, only %0d finished", target, pulses_done);
      bench_errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("FAILED %0t %s expected %h actual %h", $time, name, expected, actual);
      bench_errors++;
    end
  endtask

  task automatic report_test(input string name);
    int unsigned now_errors;
    now_errors = error_total();
    if (now_errors == errors_before)
    begin
      pass_count++;
      $display("Test %s passed", name);
    end
    else
    begin
      fail_count++;
      $display("Test %s failed with %0d errors", name, now_errors - errors_before);
    end
    errors_before = now_errors;
  endtask

  initial
  begin
    pulse_pkg::pulse_desc_u d;
    int unsigned sent;
    int unsigned full_before;
    aresetn = 1'b0;
    s_axis_tdata = '0;
    s_axis_tvalid = 1'b0;
    phase_inc = '0;
    sent = 0;
    repeat (5) @(posedge aclk);
    #10;
    aresetn = 1'b1;

    @(negedge aclk);
    check_value("s_axis_tready", 32'd1, {31'd0, s_axis_tready});
    check_value("sync", 32'd0, {31'd0, sync});
    check_value("dout", 32'd0, {31'd0, dout});
    check_value("gate", 32'd0, {31'd0, gate});
    check_value("phase", 32'd0, phase);
    @(posedge aclk);
    #10;
    report_test("reset");

    phase_inc = 32'h0123_4567;
    for (int i = 0; i < 6; i++)
    begin
      make_random_desc(d);
      send_desc(d);
    end
    s_axis_tvalid = 1'b0;
    sent += 6;
    wait_pulses(sent);
    report_test("pulse width and sync");

    phase_inc = $random(seed);  // New increment for the second burst
    for (int i = 0; i < 5; i++)
    begin
      make_random_desc(d);
      send_desc(d);
    end
    s_axis_tvalid = 1'b0;
    sent += 5;
    wait_pulses(sent);
    report_test("phase after increment change");

    // Nine long descriptors overfill the FIFO while the first one runs
    full_before = full_cycles;
    for (int i = 0; i < 9; i++)
    begin
      d.f.rise = i + 1;
      d.f.fall = 2 * i + 3;
      d.f.stop = 50;
      d.f.poff = $random(seed);
      send_desc(d);
    end
    s_axis_tvalid = 1'b0;
    sent += 9;
    wait_pulses(sent);
    assert (full_cycles > full_before)
    else
    begin
      $display("s_axis_tready never dropped while nine descriptors were queued");
      bench_errors++;
    end
    report_test("full FIFO back-pressure");

    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_total() == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pulse sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --assert -Wno-fatal --top-module pulse_sequencer_tb \
  -f all.f -o pulse_sequencer_sim \
  && { ./obj_dir/pulse_sequencer_sim +verilator+error+limit+1000 > "$log" 2>&1 || true; } \
  || { echo "Verilator build failed"; exit 1; }

cat "$log"

grep -q "RESULT: FAIL" "$log" && { echo "Simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" "$log" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"
exit 0

//--- verilog/descriptor_fifo.sv
module descriptor_fifo
(
  input  logic                            aclk,
  input  logic                            aresetn,

  input  logic [pulse_pkg::DESC_W-1:0]    s_axis_tdata,
  input  logic                            s_axis_tvalid,
  output logic                            s_axis_tready,

  output pulse_pkg::pulse_desc_u          desc_tdata,
  output logic                            desc_tvalid,
  input  logic                            desc_tready
);

  pulse_pkg::pulse_desc_u mem [pulse_pkg::FIFO_DEPTH];

  logic [pulse_pkg::FIFO_AW-1:0] wr_ptr;
  logic [pulse_pkg::FIFO_AW-1:0] rd_ptr;
  logic [pulse_pkg::FIFO_AW:0] count;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full = (count == pulse_pkg::FIFO_DEPTH);
  assign empty = (count == '0);

  assign push = s_axis_tvalid & ~full;
  assign pop = desc_tready & ~empty;  // Acknowledge from the generator

  // Storage
  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem[wr_ptr].raw <= s_axis_tdata;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
    end
    else if (push)
    begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rd_ptr <= '0;
    end
    else if (pop)
    begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Occupancy, simultaneous push and pop leaves it unchanged
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      count <= '0;
    end
    else
    begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign s_axis_tready = ~full;

  // Head word held until acknowledged
  assign desc_tdata = mem[rd_ptr];
  assign desc_tvalid = ~empty;

endmodule

//--- verilog/phase_accumulator.sv
module phase_accumulator
(
  input  logic                            aclk,
  input  logic                            aresetn,

  input  logic                            sync,
  input  logic                            dout,
  input  logic [pulse_pkg::PHASE_W-1:0]   poff,
  input  logic [pulse_pkg::PHASE_W-1:0]   phase_inc,

  output logic [pulse_pkg::PHASE_W-1:0]   phase,
  output logic                            gate
);

  logic [pulse_pkg::PHASE_W-1:0] phase_reg;
  logic [pulse_pkg::PHASE_W-1:0] phase_next;
  logic gate_reg;

  // Load offset at pulse start, otherwise free-running
  always_comb
  begin
    if (sync)
    begin
      phase_next = poff;
    end
    else
    begin
      phase_next = phase_reg + phase_inc;  // Wraps at full width
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      phase_reg <= '0;
    end
    else
    begin
      phase_reg <= phase_next;
    end
  end

  // Gate delayed to line up with the loaded phase
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      gate_reg <= 1'b0;
    end
    else
    begin
      gate_reg <= dout;
    end
  end

  assign phase = phase_reg;
  assign gate = gate_reg;

endmodule

//--- verilog/pulse_generator.sv
module pulse_generator
(
  input  logic                            aclk,
  input  logic                            aresetn,

  input  pulse_pkg::pulse_desc_u          desc_tdata,
  input  logic                            desc_tvalid,
  output logic                            desc_tready,

  output logic [pulse_pkg::PHASE_W-1:0]   poff,
  output logic                            sync,
  output logic                            dout
);

  logic tready_reg;
  logic tready_next;
  logic sync_reg;
  logic sync_next;
  logic dout_reg;
  logic dout_next;
  logic enbl_reg;
  logic enbl_next;

  logic [pulse_pkg::CNT_W-1:0] cntr_reg;
  logic [pulse_pkg::CNT_W-1:0] cntr_next;

  pulse_pkg::pulse_desc_u data_reg;
  pulse_pkg::pulse_desc_u data_next;

  // Control state
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      tready_reg <= 1'b0;
      sync_reg <= 1'b0;
      dout_reg <= 1'b0;
      enbl_reg <= 1'b0;
      cntr_reg <= '0;
    end
    else
    begin
      tready_reg <= tready_next;
      sync_reg <= sync_next;
      dout_reg <= dout_next;
      enbl_reg <= enbl_next;
      cntr_reg <= cntr_next;
    end
  end

  // Held descriptor
  always_ff @(posedge aclk)
  begin
    data_reg <= data_next;
  end

  always_comb
  begin
    tready_next = 1'b0;  // Acknowledge is a single cycle
    sync_next = 1'b0;
    dout_next = dout_reg;
    enbl_next = enbl_reg;
    cntr_next = cntr_reg;
    data_next = data_reg;

    // Capture when idle
    if (!enbl_reg && desc_tvalid)
    begin
      tready_next = 1'b1;
      enbl_next = 1'b1;
      cntr_next = '0;
      data_next = desc_tdata;
    end

    if (enbl_reg)
    begin
      cntr_next = cntr_reg + 1'b1;

      if (cntr_reg == data_reg.f.rise)
      begin
        sync_next = 1'b1;
        dout_next = 1'b1;
      end

      if (cntr_reg == data_reg.f.fall)
      begin
        dout_next = 1'b0;
      end

      // Release, a pulse never outlives its descriptor
      if (cntr_reg == data_reg.f.stop)
      begin
        enbl_next = 1'b0;
        dout_next = 1'b0;
      end
    end
  end

  assign desc_tready = tready_reg;
  assign poff = data_reg.f.poff;
  assign sync = sync_reg;
  assign dout = dout_reg;

endmodule

//--- verilog/pulse_pkg.sv
package pulse_pkg;

  // Descriptor geometry
  localparam int DESC_W = 128;
  localparam int CNT_W = 32;
  localparam int PHASE_W = 32;

  // Descriptor buffer, power of two so the pointers wrap on their own
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);

  // One 128-bit descriptor word, moved whole or read field by field
  typedef union packed
  {
    logic [DESC_W-1:0] raw;
    struct packed
    {
      logic [PHASE_W-1:0] poff;  // Phase offset loaded on sync
      logic [CNT_W-1:0] stop;    // Release count
      logic [CNT_W-1:0] fall;    // dout low
      logic [CNT_W-1:0] rise;    // dout high
    } f;
  } pulse_desc_u;

endpackage

//--- verilog/pulse_sequencer_top.sv
module pulse_sequencer_top
(
  input  logic                            aclk,
  input  logic                            aresetn,

  // Descriptor stream from the host
  input  logic [pulse_pkg::DESC_W-1:0]    s_axis_tdata,
  input  logic                            s_axis_tvalid,
  output logic                            s_axis_tready,

  input  logic [pulse_pkg::PHASE_W-1:0]   phase_inc,

  output logic                            sync,
  output logic                            dout,
  output logic [pulse_pkg::PHASE_W-1:0]   phase,
  output logic                            gate
);

  // FIFO to generator
  pulse_pkg::pulse_desc_u desc_tdata;
  logic desc_tvalid;
  logic desc_tready;

  logic [pulse_pkg::PHASE_W-1:0] poff;

  descriptor_fifo fifo0
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .desc_tdata    (desc_tdata),
    .desc_tvalid   (desc_tvalid),
    .desc_tready   (desc_tready)
  );

  pulse_generator gen0
  (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .desc_tdata  (desc_tdata),
    .desc_tvalid (desc_tvalid),
    .desc_tready (desc_tready),
    .poff        (poff),
    .sync        (sync),
    .dout        (dout)
  );

  // Gate and phase trail dout by one cycle
  phase_accumulator acc0
  (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .sync      (sync),
    .dout      (dout),
    .poff      (poff),
    .phase_inc (phase_inc),
    .phase     (phase),
    .gate      (gate)
  );

endmodule
